/* verilog/memStage_defs.svh */
// write-back selector and load codes shared by the MEM2 slice and its testbench, widths fixed to the package typedefs
`ifndef MEM_STAGE_DEFS_SVH
`define MEM_STAGE_DEFS_SVH

// write-back source selector, 2 bits
`define WB_SEL_PC8   2'd0   // link value
`define WB_SEL_ALU   2'd1
`define WB_SEL_OUTB  2'd2   // operand B passthrough
`define WB_SEL_MEM   2'd3   // load result, not forwarded from MEM2

// load width and signedness, 3 bits
`define LOAD_WORD    3'd0
`define LOAD_BYTE    3'd1   // signed byte
`define LOAD_BYTE_U  3'd2
`define LOAD_HALF    3'd3   // signed halfword
`define LOAD_HALF_U  3'd4

// general register file depth
`define REG_COUNT    32

`endif

/* verilog/memStagePkg.sv */
// width typedefs for the MEM2/WB slice, the selector and load codes themselves live in memStage_defs.svh
package memStagePkg;

    // data or address word
    typedef logic [31:0] word_t;

    // general register number
    typedef logic [4:0] regAddr_t;

    // write-back source, coded by the WB_SEL_* macros
    typedef logic [1:0] wbSel_t;

    // load width and sign, coded by the LOAD_* macros
    typedef logic [2:0] loadType_t;

endpackage

/* verilog/mem2Reg.sv */
// MEM to MEM2 stage flops where reset and flush both load a bubble, flush beats a held stage
`timescale 1ns/10ps

module mem2Reg (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   mem2Flush,
    input  logic                   mem2Wr,      // low means stall
    input  memStagePkg::word_t     memAluOut,
    input  memStagePkg::word_t     memPc,
    input  memStagePkg::word_t     memOutB,
    input  memStagePkg::wbSel_t    memWbSel,
    input  memStagePkg::regAddr_t  memDst,
    input  logic                   memRegWr,
    input  memStagePkg::loadType_t memLoadType,
    output memStagePkg::word_t     mem2AluOut,
    output memStagePkg::word_t     mem2Pc,
    output memStagePkg::word_t     mem2OutB,
    output memStagePkg::wbSel_t    mem2WbSel,
    output memStagePkg::regAddr_t  mem2Dst,
    output logic                   mem2RegWr,
    output memStagePkg::loadType_t mem2LoadType
);

    always_ff @(posedge clk) begin
        if (reset || mem2Flush) begin
            // bubble writes nothing
            mem2AluOut   <= '0;
            mem2Pc       <= '0;
            mem2OutB     <= '0;
            mem2WbSel    <= '0;
            mem2Dst      <= '0;
            mem2RegWr    <= 1'b0;
            mem2LoadType <= '0;
        end else if (mem2Wr) begin
            mem2AluOut   <= memAluOut;
            mem2Pc       <= memPc;
            mem2OutB     <= memOutB;
            mem2WbSel    <= memWbSel;
            mem2Dst      <= memDst;
            mem2RegWr    <= memRegWr;
            mem2LoadType <= memLoadType;
        end
        // otherwise hold
    end

endmodule

/* verilog/mem2Stage.sv */
// MEM2 stage top, forwarding result is zero for loads since a hazard unit must stall that case
`timescale 1ns/10ps

`include "memStage_defs.svh"

module mem2Stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   mem2Flush,
    input  logic                   mem2Wr,
    input  memStagePkg::word_t     memAluOut,
    input  memStagePkg::word_t     memPc,
    input  memStagePkg::word_t     memOutB,
    input  memStagePkg::wbSel_t    memWbSel,
    input  memStagePkg::regAddr_t  memDst,
    input  logic                   memRegWr,
    input  memStagePkg::loadType_t memLoadType,
    output memStagePkg::word_t     mem2AluOut,
    output memStagePkg::word_t     mem2Pc,
    output memStagePkg::word_t     mem2OutB,
    output memStagePkg::wbSel_t    mem2WbSel,
    output memStagePkg::regAddr_t  mem2Dst,
    output logic                   mem2RegWr,
    output memStagePkg::loadType_t mem2LoadType,
    output memStagePkg::word_t     mem2Result    // forwarding value
);

    memStagePkg::word_t pcPlus8;

    mem2Reg u_mem2Reg (
        .clk          (clk),
        .reset        (reset),
        .mem2Flush    (mem2Flush),
        .mem2Wr       (mem2Wr),
        .memAluOut    (memAluOut),
        .memPc        (memPc),
        .memOutB      (memOutB),
        .memWbSel     (memWbSel),
        .memDst       (memDst),
        .memRegWr     (memRegWr),
        .memLoadType  (memLoadType),
        .mem2AluOut   (mem2AluOut),
        .mem2Pc       (mem2Pc),
        .mem2OutB     (mem2OutB),
        .mem2WbSel    (mem2WbSel),
        .mem2Dst      (mem2Dst),
        .mem2RegWr    (mem2RegWr),
        .mem2LoadType (mem2LoadType)
    );

    assign pcPlus8 = mem2Pc + 32'd8;   // jal/jalr link address

    // forwarding mux on the registered selector
    always_comb begin
        case (mem2WbSel)
            `WB_SEL_PC8:  mem2Result = pcPlus8;
            `WB_SEL_ALU:  mem2Result = mem2AluOut;
            `WB_SEL_OUTB: mem2Result = mem2OutB;   // moves from HI/LO/CP0 in the full core
            default:      mem2Result = '0;         // load data not ready yet
        endcase
    end

endmodule

/* verilog/loadAlign.sv */
// little-endian load alignment, an unaligned halfword uses only the upper offset bit
`timescale 1ns/10ps

`include "memStage_defs.svh"

module loadAlign (
    input  memStagePkg::word_t     rdata,
    input  logic [1:0]             byteOffset,
    input  memStagePkg::loadType_t loadType,
    output memStagePkg::word_t     loadData
);

    logic [7:0]  selByte;
    logic [15:0] selHalf;

    // pick the addressed byte
    always_comb begin
        case (byteOffset)
            2'd0:    selByte = rdata[7:0];
            2'd1:    selByte = rdata[15:8];
            2'd2:    selByte = rdata[23:16];
            default: selByte = rdata[31:24];
        endcase
    end

    // halfword by bit 1 of the address
    assign selHalf = byteOffset[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (loadType)
            `LOAD_BYTE:   loadData = {{24{selByte[7]}}, selByte};   // lb
            `LOAD_BYTE_U: loadData = {24'd0, selByte};              // lbu
            `LOAD_HALF:   loadData = {{16{selHalf[15]}}, selHalf};  // lh
            `LOAD_HALF_U: loadData = {16'd0, selHalf};              // lhu
            default:      loadData = rdata;   // lw and unknown codes
        endcase
    end

endmodule

/* verilog/wbStage.sv */
// MEM2 to WB register and final write-back mux, bus read data must be valid while the load sits in MEM2
`timescale 1ns/10ps

`include "memStage_defs.svh"

module wbStage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   mem2Wr,
    input  memStagePkg::word_t     mem2AluOut,
    input  memStagePkg::word_t     mem2Pc,
    input  memStagePkg::word_t     mem2OutB,
    input  memStagePkg::wbSel_t    mem2WbSel,
    input  memStagePkg::regAddr_t  mem2Dst,
    input  logic                   mem2RegWr,
    input  memStagePkg::loadType_t mem2LoadType,
    input  memStagePkg::word_t     dbusRdata,
    output logic                   wbRegWr,
    output memStagePkg::regAddr_t  wbDst,
    output memStagePkg::word_t     wbData
);

    memStagePkg::word_t     wbAluOut;
    memStagePkg::word_t     wbPc;
    memStagePkg::word_t     wbOutB;
    memStagePkg::wbSel_t    wbWbSel;
    memStagePkg::loadType_t wbLoadType;
    memStagePkg::word_t     wbRdata;
    memStagePkg::word_t     wbLoadData;

    // stalled MEM2 sends a bubble so a held instruction writes once
    always_ff @(posedge clk) begin
        if (reset) begin
            wbRegWr <= 1'b0;
        end else begin
            wbRegWr <= mem2RegWr & mem2Wr;
        end
    end

    always_ff @(posedge clk) begin
        wbAluOut   <= mem2AluOut;
        wbPc       <= mem2Pc;
        wbOutB     <= mem2OutB;
        wbWbSel    <= mem2WbSel;
        wbDst      <= mem2Dst;
        wbLoadType <= mem2LoadType;
        wbRdata    <= dbusRdata;   // bus answers one cycle after the request
    end

    loadAlign u_loadAlign (
        .rdata      (wbRdata),
        .byteOffset (wbAluOut[1:0]),   // low address bits
        .loadType   (wbLoadType),
        .loadData   (wbLoadData)
    );

    always_comb begin
        case (wbWbSel)
            `WB_SEL_PC8:  wbData = wbPc + 32'd8;
            `WB_SEL_ALU:  wbData = wbAluOut;
            `WB_SEL_OUTB: wbData = wbOutB;
            default:      wbData = wbLoadData;
        endcase
    end

endmodule

/* verilog/regFile.sv */
// general registers with one write and one combinational read port, r0 always reads zero
`timescale 1ns/10ps

`include "memStage_defs.svh"

module regFile (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wbRegWr,
    input  memStagePkg::regAddr_t wbDst,
    input  memStagePkg::word_t    wbData,
    input  memStagePkg::regAddr_t rfReadAddr,
    output memStagePkg::word_t    rfReadData
);

    memStagePkg::word_t regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wbRegWr && (wbDst != '0)) begin
            regs[wbDst] <= wbData;   // r0 writes dropped
        end
    end

    // no write-through, a same-cycle write shows after the edge
    assign rfReadData = (rfReadAddr == '0) ? '0 : regs[rfReadAddr];

endmodule

/* verilog/memPipeTop.sv */
// MEM2, WB and register file wired together, stall and flush come from an outside controller
`timescale 1ns/10ps

module memPipeTop (
    input  logic                   clk,
    input  logic                   reset,
    input  memStagePkg::word_t     memAluOut,
    input  memStagePkg::word_t     memPc,
    input  memStagePkg::wbSel_t    memWbSel,
    input  memStagePkg::regAddr_t  memDst,
    input  memStagePkg::word_t     memOutB,
    input  logic                   memRegWr,
    input  memStagePkg::loadType_t memLoadType,
    input  logic                   mem2Flush,
    input  logic                   mem2Wr,
    input  memStagePkg::word_t     dbusRdata,
    input  memStagePkg::regAddr_t  rfReadAddr,
    output memStagePkg::word_t     mem2Result,
    output memStagePkg::regAddr_t  mem2Dst,
    output logic                   mem2RegWr,
    output memStagePkg::word_t     rfReadData
);

    memStagePkg::word_t     mem2AluOut;
    memStagePkg::word_t     mem2Pc;
    memStagePkg::word_t     mem2OutB;
    memStagePkg::wbSel_t    mem2WbSel;
    memStagePkg::loadType_t mem2LoadType;
    logic                   wbRegWr;
    memStagePkg::regAddr_t  wbDst;
    memStagePkg::word_t     wbData;

    mem2Stage u_mem2Stage (
        .clk          (clk),
        .reset        (reset),
        .mem2Flush    (mem2Flush),
        .mem2Wr       (mem2Wr),
        .memAluOut    (memAluOut),
        .memPc        (memPc),
        .memOutB      (memOutB),
        .memWbSel     (memWbSel),
        .memDst       (memDst),
        .memRegWr     (memRegWr),
        .memLoadType  (memLoadType),
        .mem2AluOut   (mem2AluOut),
        .mem2Pc       (mem2Pc),
        .mem2OutB     (mem2OutB),
        .mem2WbSel    (mem2WbSel),
        .mem2Dst      (mem2Dst),
        .mem2RegWr    (mem2RegWr),
        .mem2LoadType (mem2LoadType),
        .mem2Result   (mem2Result)
    );

    wbStage u_wbStage (
        .clk          (clk),
        .reset        (reset),
        .mem2Wr       (mem2Wr),   // bubble into WB on stall
        .mem2AluOut   (mem2AluOut),
        .mem2Pc       (mem2Pc),
        .mem2OutB     (mem2OutB),
        .mem2WbSel    (mem2WbSel),
        .mem2Dst      (mem2Dst),
        .mem2RegWr    (mem2RegWr),
        .mem2LoadType (mem2LoadType),
        .dbusRdata    (dbusRdata),
        .wbRegWr      (wbRegWr),
        .wbDst        (wbDst),
        .wbData       (wbData)
    );

    regFile u_regFile (
        .clk        (clk),
        .reset      (reset),
        .wbRegWr    (wbRegWr),
        .wbDst      (wbDst),
        .wbData     (wbData),
        .rfReadAddr (rfReadAddr),
        .rfReadData (rfReadData)
    );

endmodule

/* sim/memPipeTb.sv */
// table-driven testbench for memPipeTop, expects the register file to start cleared and loads to be fed from dbusRdata
`timescale 1ns/10ps

`include "memStage_defs.svh"

module memPipeTb;

    localparam int  PERIOD       = 8;
    localparam int  STALL_CYCLES = 3;
    localparam time WATCHDOG     = 100000;

    typedef struct {
        string                  name;
        memStagePkg::wbSel_t    sel;
        memStagePkg::loadType_t loadType;
        memStagePkg::word_t     alu;
        memStagePkg::word_t     pc;
        memStagePkg::word_t     outB;
        memStagePkg::word_t     rdata;
        memStagePkg::regAddr_t  dst;
        logic                   regWr;
        logic                   flush;
        logic                   stall;
        memStagePkg::word_t     expResult;   // forwarding value
        memStagePkg::word_t     expPrior;    // dst before this entry
        memStagePkg::word_t     expReg;      // dst after write-back
    } testEntry_t;

    logic                   clk;
    logic                   reset;
    memStagePkg::word_t     memAluOut;
    memStagePkg::word_t     memPc;
    memStagePkg::wbSel_t    memWbSel;
    memStagePkg::regAddr_t  memDst;
    memStagePkg::word_t     memOutB;
    logic                   memRegWr;
    memStagePkg::loadType_t memLoadType;
    logic                   mem2Flush;
    logic                   mem2Wr;
    memStagePkg::word_t     dbusRdata;
    memStagePkg::regAddr_t  rfReadAddr;
    memStagePkg::word_t     mem2Result;
    memStagePkg::regAddr_t  mem2Dst;
    logic                   mem2RegWr;
    memStagePkg::word_t     rfReadData;

    testEntry_t         tests[$];
    memStagePkg::word_t shadow[`REG_COUNT];   // reference register contents
    int                 seed = 32'h047d_78c5;
    int                 errorCount = 0;
    int                 testsFailed = 0;
    logic               timedOut = 1'b0;

    memPipeTop u_dut (
        .clk         (clk),
        .reset       (reset),
        .memAluOut   (memAluOut),
        .memPc       (memPc),
        .memWbSel    (memWbSel),
        .memDst      (memDst),
        .memOutB     (memOutB),
        .memRegWr    (memRegWr),
        .memLoadType (memLoadType),
        .mem2Flush   (mem2Flush),
        .mem2Wr      (mem2Wr),
        .dbusRdata   (dbusRdata),
        .rfReadAddr  (rfReadAddr),
        .mem2Result  (mem2Result),
        .mem2Dst     (mem2Dst),
        .mem2RegWr   (mem2RegWr),
        .rfReadData  (rfReadData)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // forwarding value by selector, loads give zero
    function automatic memStagePkg::word_t forwardValue(input memStagePkg::wbSel_t sel,
            input memStagePkg::word_t pc, input memStagePkg::word_t alu,
            input memStagePkg::word_t outB);
        case (sel)
            `WB_SEL_PC8:  return pc + 32'd8;
            `WB_SEL_ALU:  return alu;
            `WB_SEL_OUTB: return outB;
            default:      return 32'd0;
        endcase
    endfunction

    // little-endian extraction plus extension
    function automatic memStagePkg::word_t alignLoad(input memStagePkg::word_t rdata,
            input logic [1:0] offset, input memStagePkg::loadType_t loadType);
        logic [7:0]  oneByte;
        logic [15:0] oneHalf;
        oneByte = 8'(rdata >> {offset, 3'b000});
        oneHalf = 16'(rdata >> {offset[1], 4'b0000});
        case (loadType)
            `LOAD_BYTE:   return {{24{oneByte[7]}}, oneByte};
            `LOAD_BYTE_U: return {24'd0, oneByte};
            `LOAD_HALF:   return {{16{oneHalf[15]}}, oneHalf};
            `LOAD_HALF_U: return {16'd0, oneHalf};
            default:      return rdata;
        endcase
    endfunction

    task automatic addEntry(input string name, input memStagePkg::wbSel_t sel,
            input memStagePkg::loadType_t loadType, input memStagePkg::word_t alu,
            input memStagePkg::word_t rdata, input memStagePkg::regAddr_t dst,
            input logic regWr, input logic flush, input logic stall);
        testEntry_t entry;
        memStagePkg::word_t wbValue;
        entry.name     = name;
        entry.sel      = sel;
        entry.loadType = loadType;
        entry.alu      = alu;
        entry.pc       = $random(seed) & 32'hffff_fffc;
        entry.outB     = $random(seed);
        entry.rdata    = rdata;
        entry.dst      = dst;
        entry.regWr    = regWr;
        entry.flush    = flush;
        entry.stall    = stall;
        entry.expResult = forwardValue(sel, entry.pc, alu, entry.outB);
        entry.expPrior  = shadow[dst];
        if (sel == `WB_SEL_MEM) begin
            wbValue = alignLoad(rdata, alu[1:0], loadType);
        end else begin
            wbValue = entry.expResult;
        end
        if (!flush && regWr && dst != 5'd0) begin
            shadow[dst] = wbValue;
        end
        entry.expReg = shadow[dst];
        tests.push_back(entry);
    endtask

    // returns 1 ns after the count-th rising edge, or flags a timeout
    task automatic waitCycles(input int count);
        int   seen;
        int   steps;
        logic lastClk;
        seen  = 0;
        steps = 0;
        #0.5;   // sample between clock transitions
        lastClk = clk;
        while (seen < count && !timedOut) begin
            #1;
            steps++;
            if (lastClk === 1'b0 && clk === 1'b1) begin
                seen++;
            end
            lastClk = clk;
            if (seen < count && steps >= (count + 1) * PERIOD) begin
                timedOut = 1'b1;   // clock stopped or too slow
            end
        end
        #0.5;
    endtask

    task automatic checkValue(input string testName, input string field,
            input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s %s expected %h actual %h", testName, field, expected, actual);
            errorCount++;
        end
    endtask

    task automatic driveBubble();
        memAluOut   = 32'd0;
        memPc       = 32'd0;
        memWbSel    = `WB_SEL_ALU;
        memDst      = 5'd0;
        memOutB     = 32'd0;
        memRegWr    = 1'b0;
        memLoadType = `LOAD_WORD;
        mem2Flush   = 1'b0;
    endtask

    task automatic runTest(input testEntry_t t);
        int errorsBefore;
        errorsBefore = errorCount;
        memAluOut   = t.alu;
        memPc       = t.pc;
        memWbSel    = t.sel;
        memDst      = t.dst;
        memOutB     = t.outB;
        memRegWr    = t.regWr;
        memLoadType = t.loadType;
        mem2Flush   = t.flush;
        mem2Wr      = 1'b1;
        rfReadAddr  = t.dst;   // watch the destination throughout
        waitCycles(1);
        if (timedOut) return;
        if (t.flush) begin
            checkValue(t.name, "mem2RegWr", 32'd0, 32'(mem2RegWr));
        end else begin
            checkValue(t.name, "mem2Result", t.expResult, mem2Result);
            checkValue(t.name, "mem2Dst", 32'(t.dst), 32'(mem2Dst));
            checkValue(t.name, "mem2RegWr", 32'(t.regWr), 32'(mem2RegWr));
        end
        driveBubble();
        dbusRdata = t.rdata;   // bus answers while the entry sits in MEM2
        if (t.stall) begin
            mem2Wr    = 1'b0;
            memAluOut = $random(seed);   // junk that must not get in
            memOutB   = $random(seed);
            memDst    = 5'd31;
            memRegWr  = 1'b1;
            for (int i = 0; i < STALL_CYCLES; i++) begin
                waitCycles(1);
                if (timedOut) return;
                checkValue(t.name, "held mem2Result", t.expResult, mem2Result);
                checkValue(t.name, "held mem2Dst", 32'(t.dst), 32'(mem2Dst));
                checkValue(t.name, "held mem2RegWr", 32'(t.regWr), 32'(mem2RegWr));
            end
            driveBubble();
            mem2Wr = 1'b1;
            checkValue(t.name, "dst during stall", t.expPrior, rfReadData);
        end
        waitCycles(2);
        if (timedOut) return;
        checkValue(t.name, "register", t.expReg, rfReadData);
        if (t.stall) begin
            waitCycles(2);   // no second write may follow
            if (timedOut) return;
            checkValue(t.name, "register after release", t.expReg, rfReadData);
        end
        if (errorCount == errorsBefore) begin
            $display("test %s: passed", t.name);
        end else begin
            $display("test %s: %0d errors", t.name, errorCount - errorsBefore);
            testsFailed++;
        end
    endtask

    initial begin
        memStagePkg::loadType_t loadCodes[5];
        memStagePkg::word_t     addr;
        int                     resetErrors;
        reset      = 1'b1;
        mem2Wr     = 1'b1;
        dbusRdata  = 32'd0;
        rfReadAddr = 5'd0;
        driveBubble();
        memAluOut  = 32'h1357_9bdf;   // a live write that reset must block
        memDst     = 5'd5;
        memRegWr   = 1'b1;
        for (int i = 0; i < `REG_COUNT; i++) begin
            shadow[i] = 32'd0;
        end
        loadCodes = '{`LOAD_WORD, `LOAD_BYTE, `LOAD_BYTE_U, `LOAD_HALF, `LOAD_HALF_U};

        addEntry("link_pc8", `WB_SEL_PC8, `LOAD_WORD, $random(seed), 32'd0, 5'd1, 1'b1, 1'b0, 1'b0);
        addEntry("alu_out", `WB_SEL_ALU, `LOAD_WORD, $random(seed), 32'd0, 5'd2, 1'b1, 1'b0, 1'b0);
        addEntry("operand_b", `WB_SEL_OUTB, `LOAD_WORD, $random(seed), 32'd0, 5'd3, 1'b1,
                 1'b0, 1'b0);
        for (int lt = 0; lt < 5; lt++) begin
            for (int off = 0; off < 4; off++) begin
                addr = ($random(seed) & 32'hffff_fffc) | 32'(off);
                // sign bits set in every byte and halfword
                addEntry($sformatf("load_type%0d_off%0d", lt, off), `WB_SEL_MEM, loadCodes[lt],
                         addr, $random(seed) | 32'h8080_8080, 5'(4 + lt * 4 + off),
                         1'b1, 1'b0, 1'b0);
            end
        end
        addEntry("write_r0", `WB_SEL_ALU, `LOAD_WORD, $random(seed), 32'd0, 5'd0, 1'b1, 1'b0, 1'b0);
        addEntry("no_regwr", `WB_SEL_ALU, `LOAD_WORD, $random(seed), 32'd0, 5'd1, 1'b0, 1'b0, 1'b0);
        addEntry("flushed", `WB_SEL_ALU, `LOAD_WORD, $random(seed), 32'd0, 5'd2, 1'b1, 1'b1, 1'b0);
        addEntry("stall_hold", `WB_SEL_ALU, `LOAD_WORD, $random(seed), 32'd0, 5'd4, 1'b1,
                 1'b0, 1'b1);   // r4 already holds a load

        waitCycles(8);
        resetErrors = errorCount;
        checkValue("reset", "mem2RegWr", 32'd0, 32'(mem2RegWr));
        checkValue("reset", "mem2Dst", 32'd0, 32'(mem2Dst));
        driveBubble();
        reset = 1'b0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            rfReadAddr = 5'(i);
            waitCycles(1);
            checkValue("reset", $sformatf("r%0d", i), 32'd0, rfReadData);
        end
        if (errorCount == resetErrors) begin
            $display("test reset: passed");
        end else begin
            $display("test reset: %0d errors", errorCount - resetErrors);
            testsFailed++;
        end

        foreach (tests[i]) begin
            if (timedOut) break;
            runTest(tests[i]);
        end

        $display("tests run %0d, failed %0d, check errors %0d", tests.size() + 1, testsFailed,
                 errorCount);
        if (timedOut) begin
            $display("timeout while waiting for clock edges");
        end
        if (timedOut || errorCount != 0) begin
            $display("Simulation failed");
        end else begin
            $display("Simulation completed successfully");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG);
        $display("watchdog expired, the run did not finish in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

/* compile.f */
+incdir+verilog
verilog/memStagePkg.sv
verilog/mem2Reg.sv
verilog/mem2Stage.sv
verilog/loadAlign.sv
verilog/wbStage.sv
verilog/regFile.sv
verilog/memPipeTop.sv
sim/memPipeTb.sv

/* run.sh */
#!/usr/bin/env bash
# builds memPipeTb with Verilator and runs it, failing if the log reports a failure

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG_FILE=sim.log

verilator --binary --timing --assert -f compile.f --top-module memPipeTb -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/VmemPipeTb" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG_FILE"; then
    echo "FAILED, see $LOG_FILE"
    exit 1
fi

echo "PASSED"
exit 0
